// ==== verilog/bridge_pkg.sv ====
package bridge_pkg;

  // bus widths
  typedef logic [63:0] addr_t;
  typedef logic [63:0] data_t;

  // cpu index: bit 31 active flag, bits 30..0 rank
  typedef logic [31:0] cpu_index_t;
  typedef logic [7:0]  cpu_msg_t;
  typedef logic [1:0]  cpu_rel_t;

  // core FSM lives outside, its state comes in as a plain code
  typedef logic [7:0]  core_state_t;

  // broadcast index relative to own index
  localparam cpu_rel_t REL_NONE = 2'b00;
  localparam cpu_rel_t REL_LT   = 2'b01;
  localparam cpu_rel_t REL_GT   = 2'b10;
  localparam cpu_rel_t REL_EQ   = 2'b11;

  // core state codes
  localparam core_state_t WAIT_FOR_START   = 8'h00;
  localparam core_state_t START_BEGIN      = 8'h01;
  // read group
  localparam core_state_t READ_COND        = 8'h10;
  localparam core_state_t READ_COND_P      = 8'h11;
  localparam core_state_t READ_SRC1        = 8'h12;
  localparam core_state_t READ_SRC1_P      = 8'h13;
  localparam core_state_t READ_SRC0        = 8'h14;
  localparam core_state_t READ_SRC0_P      = 8'h15;
  localparam core_state_t READ_DST         = 8'h16;
  localparam core_state_t START_READ_CMD   = 8'h17;
  localparam core_state_t START_READ_CMD_P = 8'h18;
  // write group
  localparam core_state_t WRITE_REG_IP     = 8'h20;
  localparam core_state_t WRITE_DST        = 8'h21;
  localparam core_state_t WRITE_DST_P      = 8'h22;
  localparam core_state_t WRITE_SRC1       = 8'h23;
  localparam core_state_t WRITE_SRC0       = 8'h24;
  localparam core_state_t WRITE_COND       = 8'h25;
  // execute and finish
  localparam core_state_t ALU_BEGIN        = 8'h30;
  localparam core_state_t FINISH_BEGIN     = 8'h40;
  localparam core_state_t FINISH_END       = 8'h41;

  // inter-cpu messages
  localparam cpu_msg_t CPU_R_NONE      = 8'h00;
  localparam cpu_msg_t CPU_R_RESET     = 8'h01;
  localparam cpu_msg_t CPU_R_START     = 8'h02;
  localparam cpu_msg_t CPU_R_END       = 8'h03;
  localparam cpu_msg_t CPU_R_FORK_DONE = 8'h04;
  localparam cpu_msg_t CPU_R_STOP_DONE = 8'h05;

  localparam cpu_index_t CPU_ACTIVE    = 32'h8000_0000;
  localparam cpu_index_t CPU_NONACTIVE = 32'h0000_0000;

  // thread header size, first data word follows it
  localparam int THREAD_HEADER_DEF = 16;

endpackage

// ==== verilog/bridge_join_seq.sv ====
module bridge_join_seq import bridge_pkg::*; (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  core_state_t core_state,
  input  logic        finish_seen,
  output logic        join_done,
  output logic        load_index,
  output logic        reset_msg,
  output logic        rst,
  output logic        ext_rst_e,
  output logic        dispatcher_set
);

  typedef enum logic [2:0] {
    JS_IDLE,
    JS_CHECK,
    JS_LOAD,
    JS_ASSERT,
    JS_RELEASE,
    JS_RUN
  } join_state_t;

  join_state_t state;
  join_state_t state_next;

  // one step per cycle, RUN holds until the core has finished
  always_comb begin
    state_next = state;
    case (state)
      JS_IDLE: begin
        state_next = JS_CHECK;
      end
      JS_CHECK: begin
        // finished core keeps its slot, no index reload
        if (core_state == FINISH_END) begin
          state_next = JS_ASSERT;
        end else begin
          state_next = JS_LOAD;
        end
      end
      JS_LOAD: begin
        state_next = JS_ASSERT;
      end
      JS_ASSERT: begin
        state_next = JS_RELEASE;
      end
      JS_RELEASE: begin
        state_next = JS_RUN;
      end
      JS_RUN: begin
        if (finish_seen) begin
          state_next = JS_IDLE;
        end
      end
      default: begin
        state_next = JS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      state     <= JS_IDLE;
      rst       <= 1'b0;
      ext_rst_e <= 1'b0;
    end else begin
      state <= state_next;
      // core reset, one cycle wide
      rst   <= (state == JS_ASSERT);
      // outside reset only for a fresh join
      ext_rst_e <= (state == JS_ASSERT) && (core_state != FINISH_END);
    end
  end

  // index capture and reset broadcast share the LOAD step
  assign load_index     = (state == JS_LOAD);
  assign reset_msg      = (state == JS_LOAD);
  assign dispatcher_set = (state == JS_RELEASE);
  assign join_done      = (state == JS_RUN);

endmodule

// ==== verilog/cpu_rank_tracker.sv ====
module cpu_rank_tracker import bridge_pkg::*; (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  logic        load_index,
  input  logic        finish_seen,
  input  core_state_t core_state,
  input  cpu_index_t  ext_cpu_index,
  input  cpu_msg_t    ext_cpu_msg_in,
  input  logic        ext_next_cpu_q,
  input  logic        ext_next_cpu_e,
  output cpu_index_t  cpu_index,
  output cpu_rel_t    cpu_ind_rel
);

  cpu_index_t idx_next;
  logic       ext_active;
  logic       own_active;
  logic       ext_rank_lt;
  logic       ext_rank_gt;

  assign ext_active  = ext_cpu_index[31];
  assign own_active  = cpu_index[31];
  // ranks only, active flag ignored
  assign ext_rank_lt = ext_cpu_index[30:0] < cpu_index[30:0];
  assign ext_rank_gt = ext_cpu_index[30:0] > cpu_index[30:0];

  // rank bookkeeping from the broadcast index and message
  always_comb begin
    idx_next = cpu_index;
    if (ext_cpu_index == cpu_index) begin
      // first thread start of a fresh core
      if (cpu_index == CPU_NONACTIVE && core_state == START_BEGIN) begin
        idx_next = CPU_ACTIVE;
      end
    end else if (ext_active) begin
      // a lower ranked core left, move down one
      if (ext_cpu_msg_in == CPU_R_END && own_active && ext_rank_lt) begin
        idx_next[30:0] = cpu_index[30:0] - 31'd1;
      end
    end else if (ext_cpu_msg_in == CPU_R_START) begin
      // new core joined
      if (own_active) begin
        idx_next[30:0] = cpu_index[30:0] + 31'd1;
      end else begin
        idx_next[30:0] = cpu_index[30:0] - 31'd1;
      end
    end
    if (core_state == START_BEGIN) begin
      idx_next[31] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_index <= CPU_NONACTIVE;
    end else if (finish_seen) begin
      cpu_index <= CPU_NONACTIVE;
    end else if (load_index) begin
      // join step takes the broadcast index as own
      cpu_index <= ext_cpu_index;
    end else begin
      cpu_index <= idx_next;
    end
  end

  // relation is sampled with the token strobe
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_ind_rel <= REL_NONE;
    end else if (ext_next_cpu_q) begin
      if (ext_rank_lt) begin
        cpu_ind_rel <= REL_LT;
      end else if (ext_rank_gt) begin
        cpu_ind_rel <= REL_GT;
      end else if (ext_cpu_index == cpu_index) begin
        cpu_ind_rel <= REL_EQ;
      end
      // same rank but other flag keeps the old relation
    end else if (ext_next_cpu_e) begin
      cpu_ind_rel <= REL_NONE;
    end
  end

endmodule

// ==== verilog/bus_token_ctrl.sv ====
module bus_token_ctrl import bridge_pkg::*; #(
  parameter int THREAD_HEADER_SPACE = THREAD_HEADER_DEF
) (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  logic        join_done,
  input  logic        dispatcher_set,
  input  logic        reset_msg,
  input  core_state_t core_state,
  input  cpu_index_t  cpu_index,
  input  cpu_rel_t    cpu_ind_rel,
  input  logic        ext_next_cpu_q,
  input  cpu_msg_t    ext_cpu_msg_in,
  input  logic        bus_busy,
  input  logic        read_q,
  input  logic        write_q,
  input  addr_t       addr_in,
  input  data_t       data_in,
  output logic        ext_next_cpu_e,
  output logic        next_state,
  output logic        disp_online,
  output logic        ext_dispatcher_q,
  output cpu_msg_t    ext_cpu_msg,
  output cpu_index_t  ext_cpu_index_out,
  output addr_t       base_addr,
  output addr_t       base_addr_data,
  output logic        finish_seen,
  output logic        ext_read_q,
  output logic        ext_write_q
);

  logic tok_hit;
  logic in_read;
  logic in_write;
  logic done_msg;

  // core state groups that use the bus
  assign in_read = core_state inside {READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P,
                                      READ_SRC0, READ_SRC0_P, READ_DST,
                                      START_READ_CMD, START_READ_CMD_P};
  assign in_write = core_state inside {WRITE_REG_IP, WRITE_DST, WRITE_DST_P,
                                       WRITE_SRC1, WRITE_SRC0, WRITE_COND};

  // token addressed to this core, relation from last cycle
  assign tok_hit  = ext_next_cpu_q && (cpu_ind_rel == REL_EQ);
  assign done_msg = (ext_cpu_msg_in == CPU_R_FORK_DONE) ||
                    (ext_cpu_msg_in == CPU_R_STOP_DONE);

  // control state
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_next_cpu_e    <= 1'b0;
      next_state        <= 1'b0;
      disp_online       <= 1'b0;
      ext_dispatcher_q  <= 1'b0;
      ext_cpu_msg       <= CPU_R_NONE;
      ext_cpu_index_out <= CPU_NONACTIVE;
    end else begin
      // message and index out are single cycle
      next_state        <= 1'b0;
      ext_cpu_msg       <= CPU_R_NONE;
      ext_cpu_index_out <= CPU_NONACTIVE;
      if (reset_msg) begin
        ext_cpu_msg <= CPU_R_RESET;
      end
      if (!join_done) begin
        // join in progress, bus side idle
        ext_next_cpu_e   <= 1'b0;
        disp_online      <= 1'b0;
        ext_dispatcher_q <= dispatcher_set;
      end else if (!bus_busy) begin
        // hand back the token once the transfer is over
        if (ext_next_cpu_e && !read_q && !write_q) begin
          ext_next_cpu_e <= 1'b0;
          disp_online    <= 1'b0;
        end else if (disp_online && (read_q || write_q)) begin
          ext_next_cpu_e <= 1'b1;
        end
        if (tok_hit) begin
          disp_online <= 1'b1;
          if (core_state == WAIT_FOR_START) begin
            ext_cpu_msg       <= CPU_R_START;
            ext_cpu_index_out <= cpu_index;
            ext_next_cpu_e    <= 1'b1;
            next_state        <= 1'b1;
          end else if (core_state == FINISH_BEGIN) begin
            ext_cpu_msg       <= CPU_R_END;
            ext_cpu_index_out <= cpu_index;
            ext_next_cpu_e    <= 1'b1;
            next_state        <= 1'b1;
          end else if (in_read || in_write) begin
            ext_dispatcher_q <= 1'b1;
          end
        end else if (in_read || in_write) begin
          ext_dispatcher_q <= 1'b1;
        end else if (core_state == ALU_BEGIN) begin
          // fork or stop acknowledge
          if (done_msg) begin
            ext_next_cpu_e <= 1'b1;
          end
        end else if (core_state != START_BEGIN && core_state != FINISH_END) begin
          ext_dispatcher_q <= 1'b0;
        end
      end
    end
  end

  // thread base addresses, loaded on the start token
  always_ff @(posedge clk) begin
    if (join_done && !bus_busy && tok_hit && core_state == WAIT_FOR_START) begin
      base_addr <= addr_in + addr_t'(THREAD_HEADER_SPACE);
      // no separate data block, data follows the header
      if (data_in != '0) begin
        base_addr_data <= data_in + addr_t'(THREAD_HEADER_SPACE);
      end else begin
        base_addr_data <= addr_in + addr_t'(THREAD_HEADER_SPACE);
      end
    end
  end

  // core done and not holding the token, restart the join
  assign finish_seen = join_done && !bus_busy && !tok_hit && (core_state == FINISH_END);

  // strobes reach the bus only while dispatching
  assign ext_read_q  = disp_online && in_read && read_q;
  assign ext_write_q = disp_online && in_write && write_q;

endmodule

// ==== verilog/bridge_to_outside.sv ====
module bridge_to_outside import bridge_pkg::*; #(
  parameter int THREAD_HEADER_SPACE = THREAD_HEADER_DEF
) (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  core_state_t core_state,
  input  cpu_index_t  ext_cpu_index,
  input  cpu_msg_t    ext_cpu_msg_in,
  input  logic        ext_next_cpu_q,
  input  logic        bus_busy,
  input  logic        read_q,
  input  logic        write_q,
  input  addr_t       addr_in,
  input  data_t       data_in,
  output logic        rst,
  output logic        ext_rst_e,
  output cpu_index_t  cpu_index,
  output cpu_rel_t    cpu_ind_rel,
  output logic        ext_next_cpu_e,
  output logic        next_state,
  output logic        disp_online,
  output logic        ext_dispatcher_q,
  output cpu_msg_t    ext_cpu_msg,
  output cpu_index_t  ext_cpu_index_out,
  output addr_t       base_addr,
  output addr_t       base_addr_data,
  output logic        ext_read_q,
  output logic        ext_write_q
);

  // join sequencer to the other blocks
  logic join_done;
  logic load_index;
  logic reset_msg;
  logic dispatcher_set;
  // finish detect back to sequencer and tracker
  logic finish_seen;

  bridge_join_seq join_seq_i (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .core_state     (core_state),
    .finish_seen    (finish_seen),
    .join_done      (join_done),
    .load_index     (load_index),
    .reset_msg      (reset_msg),
    .rst            (rst),
    .ext_rst_e      (ext_rst_e),
    .dispatcher_set (dispatcher_set)
  );

  cpu_rank_tracker rank_i (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .load_index     (load_index),
    .finish_seen    (finish_seen),
    .core_state     (core_state),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .ext_next_cpu_q (ext_next_cpu_q),
    .ext_next_cpu_e (ext_next_cpu_e),
    .cpu_index      (cpu_index),
    .cpu_ind_rel    (cpu_ind_rel)
  );

  bus_token_ctrl #(
    .THREAD_HEADER_SPACE (THREAD_HEADER_SPACE)
  ) token_i (
    .clk               (clk),
    .ext_rst_b         (ext_rst_b),
    .join_done         (join_done),
    .dispatcher_set    (dispatcher_set),
    .reset_msg         (reset_msg),
    .core_state        (core_state),
    .cpu_index         (cpu_index),
    .cpu_ind_rel       (cpu_ind_rel),
    .ext_next_cpu_q    (ext_next_cpu_q),
    .ext_cpu_msg_in    (ext_cpu_msg_in),
    .bus_busy          (bus_busy),
    .read_q            (read_q),
    .write_q           (write_q),
    .addr_in           (addr_in),
    .data_in           (data_in),
    .ext_next_cpu_e    (ext_next_cpu_e),
    .next_state        (next_state),
    .disp_online       (disp_online),
    .ext_dispatcher_q  (ext_dispatcher_q),
    .ext_cpu_msg       (ext_cpu_msg),
    .ext_cpu_index_out (ext_cpu_index_out),
    .base_addr         (base_addr),
    .base_addr_data    (base_addr_data),
    .finish_seen       (finish_seen),
    .ext_read_q        (ext_read_q),
    .ext_write_q       (ext_write_q)
  );

endmodule

// ==== test/tb_bridge_ref.svh ====
`ifndef TB_BRIDGE_REF_SVH
`define TB_BRIDGE_REF_SVH

// 32 bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// expected own index after one cycle of broadcast traffic
function automatic cpu_index_t ref_rank(input cpu_index_t own, input cpu_index_t ext,
                                        input cpu_msg_t msg, input core_state_t st);
  cpu_index_t r;
  r = own;
  if (ext == own) begin
    // fresh core starting its first thread
    if (own == CPU_NONACTIVE && st == START_BEGIN) begin
      r = CPU_ACTIVE;
    end
  end else if (ext[31]) begin
    // lower ranked active core ends
    if (msg == CPU_R_END && own[31] && ext[30:0] < own[30:0]) begin
      r[30:0] = own[30:0] - 31'd1;
    end
  end else if (msg == CPU_R_START) begin
    r[30:0] = own[31] ? own[30:0] + 31'd1 : own[30:0] - 31'd1;
  end
  if (st == START_BEGIN) begin
    r[31] = 1'b1;
  end
  return r;
endfunction

// relation of broadcast to own index, equal rank with other flag keeps old value
function automatic cpu_rel_t ref_rel(input cpu_index_t own, input cpu_index_t ext,
                                     input cpu_rel_t old);
  if (ext[30:0] < own[30:0]) return REL_LT;
  if (ext[30:0] > own[30:0]) return REL_GT;
  if (ext == own) return REL_EQ;
  return old;
endfunction

function automatic addr_t ref_base(input addr_t a, input int space);
  return a + addr_t'(space);
endfunction

// data block base, falls back to the code base when data_in is zero
function automatic addr_t ref_base_data(input addr_t a, input data_t d, input int space);
  if (d != '0) return d + addr_t'(space);
  return a + addr_t'(space);
endfunction

function automatic logic is_read_state(input core_state_t st);
  return st inside {READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P, READ_SRC0,
                    READ_SRC0_P, READ_DST, START_READ_CMD, START_READ_CMD_P};
endfunction

function automatic logic is_write_state(input core_state_t st);
  return st inside {WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1, WRITE_SRC0,
                    WRITE_COND};
endfunction

// a strobe passes only while dispatching in its own group
function automatic logic ref_gate(input logic online, input logic grp, input logic strobe);
  return online & grp & strobe;
endfunction

`endif

// ==== test/tb_bridge_to_outside.sv ====
module tb_bridge_to_outside import bridge_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HDR_SPACE = 16;
  localparam int N_REL = 40;
  localparam int N_RANK = 60;
  localparam int N_GATE = 30;
  localparam int N_IDLE = 8;
  // join, three token runs, loops, restart, with margin
  localparam int CYCLE_LIMIT = 4 * (18 + 3 * 12 + N_REL + N_RANK + N_GATE + N_IDLE + 12) + 500;

  logic clk;
  logic ext_rst_b;
  core_state_t core_state;
  cpu_index_t ext_cpu_index;
  cpu_msg_t ext_cpu_msg_in;
  logic ext_next_cpu_q;
  logic bus_busy;
  logic read_q;
  logic write_q;
  addr_t addr_in;
  data_t data_in;
  logic rst;
  logic ext_rst_e;
  cpu_index_t cpu_index;
  cpu_rel_t cpu_ind_rel;
  logic ext_next_cpu_e;
  logic next_state;
  logic disp_online;
  logic ext_dispatcher_q;
  cpu_msg_t ext_cpu_msg;
  cpu_index_t ext_cpu_index_out;
  addr_t base_addr;
  addr_t base_addr_data;
  logic ext_read_q;
  logic ext_write_q;

  logic [31:0] rng_state = 32'd17441;
  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int tests = 0;
  int tests_failed = 0;
  int err_start;
  int rst_cnt;
  int rst_at;
  int erst_cnt;
  int erst_at;
  int msg_cnt;
  int msg_at;
  int disp_at;
  int read_hits;
  int write_hits;
  logic gate_chk = 1'b0;
  // dispatch window as the stimulus opens and closes it
  logic online_exp = 1'b0;
  logic [31:0] r;
  cpu_index_t own;
  cpu_index_t ext;
  cpu_index_t idx_exp;
  cpu_rel_t rel_exp;
  cpu_msg_t msg;

  `include "tb_bridge_ref.svh"

  bridge_to_outside #(
    .THREAD_HEADER_SPACE (HDR_SPACE)
  ) bridge_to_outside_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic tick();
    @(negedge clk);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != err_start) tests_failed++;
    $display("test %s %s, %0d errors", name, (errors == err_start) ? "ok" : "failed",
             errors - err_start);
    err_start = errors;
  endtask

  // strobe gating, sampled once inputs have settled
  always @(negedge clk) begin
    #1;
    if (gate_chk) begin
      check_val("ext_read_q", 64'(ext_read_q),
                64'(ref_gate(online_exp, is_read_state(core_state), read_q)));
      check_val("ext_write_q", 64'(ext_write_q),
                64'(ref_gate(online_exp, is_write_state(core_state), write_q)));
    end
  end

  // leave cpu_ind_rel away from REL_EQ so the next token takes two cycles
  task automatic spoil_rel();
    bus_busy = 1'b1;
    ext_next_cpu_q = 1'b1;
    ext_cpu_index = {1'b1, own[30:0] + 31'd1};
    tick();
    ext_next_cpu_q = 1'b0;
    ext_cpu_index = own;
    bus_busy = 1'b0;
  endtask

  // matching token in a start or finish state, then a short read burst
  task automatic take_token(input core_state_t st, input addr_t a, input data_t d,
                            input cpu_msg_t exp_msg);
    spoil_rel();
    core_state = st;
    addr_in = a;
    data_in = d;
    ext_next_cpu_q = 1'b1;
    // first edge registers REL_EQ, second one takes the token
    tick();
    tick();
    check_val("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd1);
    check_val("disp_online", 64'(disp_online), 64'd1);
    check_val("next_state", 64'(next_state), 64'd1);
    check_val("ext_cpu_msg", 64'(ext_cpu_msg), 64'(exp_msg));
    check_val("ext_cpu_index_out", 64'(ext_cpu_index_out), 64'(own));
    if (st == WAIT_FOR_START) begin
      check_val("base_addr", base_addr, ref_base(a, HDR_SPACE));
      check_val("base_addr_data", base_addr_data, ref_base_data(a, d, HDR_SPACE));
    end
    ext_next_cpu_q = 1'b0;
    read_q = 1'b1;
    tick();
    check_val("next_state", 64'(next_state), 64'd0);
    check_val("ext_cpu_msg", 64'(ext_cpu_msg), 64'(CPU_R_NONE));
    check_val("ext_cpu_index_out", 64'(ext_cpu_index_out), 64'd0);
    check_val("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd1);
    // grant held without the token strobe drops the relation
    check_val("cpu_ind_rel", 64'(cpu_ind_rel), 64'(REL_NONE));
    read_q = 1'b0;
    tick();
    check_val("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd0);
    check_val("disp_online", 64'(disp_online), 64'd0);
  endtask

  initial begin
    ext_rst_b = 1'b1;
    core_state = WAIT_FOR_START;
    ext_cpu_index = '0;
    ext_cpu_msg_in = CPU_R_NONE;
    ext_next_cpu_q = 1'b0;
    bus_busy = 1'b0;
    read_q = 1'b0;
    write_q = 1'b0;
    addr_in = '0;
    data_in = '0;
    err_start = 0;
    repeat (8) tick();

    // all control outputs idle in reset
    check_val("rst", 64'(rst), 64'd0);
    check_val("ext_rst_e", 64'(ext_rst_e), 64'd0);
    check_val("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd0);
    check_val("next_state", 64'(next_state), 64'd0);
    check_val("disp_online", 64'(disp_online), 64'd0);
    check_val("ext_dispatcher_q", 64'(ext_dispatcher_q), 64'd0);
    check_val("ext_cpu_msg", 64'(ext_cpu_msg), 64'(CPU_R_NONE));

    // join after external reset
    own = {1'b1, 31'(200 + next_rand() % 100)};
    ext_cpu_index = own;
    ext_rst_b = 1'b0;
    rst_cnt = 0;
    rst_at = 0;
    erst_cnt = 0;
    erst_at = 0;
    msg_cnt = 0;
    msg_at = 0;
    disp_at = 0;
    for (int k = 1; k <= 10; k++) begin
      tick();
      if (rst) begin
        rst_cnt++;
        rst_at = k;
      end
      if (ext_rst_e) begin
        erst_cnt++;
        erst_at = k;
      end
      if (ext_cpu_msg == CPU_R_RESET) begin
        msg_cnt++;
        msg_at = k;
      end
      if (ext_dispatcher_q && disp_at == 0) begin
        disp_at = k;
      end
    end
    check_true(rst_cnt == 1, "rst did not pulse exactly once during the join");
    check_val("rst rise cycle", 64'(rst_at), 64'd4);
    check_true(erst_cnt == 1, "ext_rst_e did not pulse exactly once during the join");
    check_val("ext_rst_e rise cycle", 64'(erst_at), 64'd4);
    check_true(msg_cnt == 1, "reset message was not sent exactly once");
    check_val("reset message cycle", 64'(msg_at), 64'd3);
    // release step follows the reset step
    check_val("ext_dispatcher_q rise cycle", 64'(disp_at), 64'd5);
    check_val("cpu_index", 64'(cpu_index), 64'(own));
    end_test("join");

    // relation, token side held off by bus_busy
    bus_busy = 1'b1;
    ext_next_cpu_q = 1'b1;
    rel_exp = REL_NONE;
    for (int i = 0; i < N_REL; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0: ext = own;
        2'd1: ext = {~own[31], own[30:0]};
        default: ext = {r[31], own[30:0] + 31'(r[10:4]) - 31'd64};
      endcase
      ext_cpu_index = ext;
      rel_exp = ref_rel(own, ext, rel_exp);
      tick();
      check_val("cpu_ind_rel", 64'(cpu_ind_rel), 64'(rel_exp));
    end
    ext_next_cpu_q = 1'b0;
    ext_cpu_index = own;
    bus_busy = 1'b0;
    end_test("relation");

    // thread start, code only and separate data block
    take_token(WAIT_FOR_START, {next_rand(), next_rand()}, '0, CPU_R_START);
    take_token(WAIT_FOR_START, {next_rand(), next_rand()}, {next_rand(), next_rand() | 32'h1},
               CPU_R_START);
    end_test("start");

    // rank bookkeeping on broadcasts
    bus_busy = 1'b1;
    for (int i = 0; i < N_RANK; i++) begin
      r = next_rand();
      msg = r[0] ? CPU_R_START : CPU_R_END;
      ext = {r[1], own[30:0] + 31'(r[6:2]) - 31'd16};
      ext_cpu_msg_in = msg;
      ext_cpu_index = ext;
      idx_exp = ref_rank(own, ext, msg, core_state);
      tick();
      check_val("cpu_index", 64'(cpu_index), 64'(idx_exp));
      own = idx_exp;
    end
    ext_cpu_msg_in = CPU_R_NONE;
    ext_cpu_index = own;
    bus_busy = 1'b0;
    end_test("rank");

    // finish with token, gating, then finish without token
    take_token(FINISH_BEGIN, '0, '0, CPU_R_END);
    spoil_rel();
    core_state = READ_SRC0;
    ext_next_cpu_q = 1'b1;
    write_q = 1'b1;
    tick();
    tick();
    check_val("disp_online", 64'(disp_online), 64'd1);
    // read group sets the dispatcher line
    check_val("ext_dispatcher_q", 64'(ext_dispatcher_q), 64'd1);
    ext_next_cpu_q = 1'b0;
    online_exp = 1'b1;
    gate_chk = 1'b1;
    read_hits = 0;
    write_hits = 0;
    for (int i = 0; i < N_GATE; i++) begin
      r = next_rand();
      case (r[2:0])
        3'd0: core_state = READ_DST;
        3'd1: core_state = WRITE_DST;
        3'd2: core_state = ALU_BEGIN;
        3'd3: core_state = START_READ_CMD_P;
        3'd4: core_state = WRITE_COND;
        default: core_state = READ_COND;
      endcase
      // one strobe stays high so the dispatch stays open
      read_q = r[3];
      write_q = ~r[3] | r[4];
      tick();
      if (ext_read_q) read_hits++;
      if (ext_write_q) write_hits++;
    end
    read_q = 1'b0;
    write_q = 1'b0;
    online_exp = 1'b0;
    tick();
    check_val("disp_online", 64'(disp_online), 64'd0);
    check_val("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd0);
    check_true(read_hits > 0, "read strobe never reached the bus");
    check_true(write_hits > 0, "write strobe never reached the bus");
    // strobes without the token stay off the bus
    for (int i = 0; i < N_IDLE; i++) begin
      r = next_rand();
      core_state = r[0] ? READ_DST : WRITE_DST;
      read_q = r[1];
      write_q = r[2];
      tick();
    end
    read_q = 1'b0;
    write_q = 1'b0;
    tick();
    gate_chk = 1'b0;

    core_state = FINISH_END;
    ext_cpu_index = '0;
    rst_cnt = 0;
    rst_at = 0;
    erst_cnt = 0;
    for (int k = 1; k <= 8; k++) begin
      tick();
      if (k == 1) check_val("cpu_index", 64'(cpu_index), 64'(CPU_NONACTIVE));
      if (rst) begin
        rst_cnt++;
        rst_at = k;
      end
      if (ext_rst_e) erst_cnt++;
    end
    check_true(rst_cnt == 1, "rst did not pulse exactly once after the core finished");
    check_val("rst rise cycle", 64'(rst_at), 64'd4);
    check_true(erst_cnt == 0, "ext_rst_e pulsed on a rejoin after finish");
    core_state = WAIT_FOR_START;
    end_test("finish");

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, tests_failed, checks,
             errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+test
verilog/bridge_pkg.sv
verilog/bridge_join_seq.sv
verilog/cpu_rank_tracker.sv
verilog/bus_token_ctrl.sv
verilog/bridge_to_outside.sv
test/tb_bridge_to_outside.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

LOG=sim.log

verilator --binary -f verilog.f --top-module tb_bridge_to_outside -o sim_bridge
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  exit 1
fi
exit 0
